//--- project.f
rtl/adc_if_pkg.sv
rtl/adc_align_if.sv
rtl/adc_ddr_capture.sv
rtl/adc_pattern_check.sv
rtl/adc_window_timer.sv
rtl/adc_align_fsm.sv
rtl/adc_if_top.sv
sim/adc_if_assertions.sv
sim/tb_adc_if.sv

//--- rtl/adc_align_fsm.sv
/* calibration fsm
   four-phase cal_req/cal_ack handshake, tries edge select 0 then 1
   against the adc test pattern and reports the result on cal_ok */

module adc_align_fsm (
  input  logic                   adc_clk,
  input  logic                   arst_n,
  input  logic                   cal_req,
  output logic                   cal_ack,
  output logic                   cal_ok,
  adc_align_if.fsm_mp            align,
  output logic                   tmr_start,
  output adc_if_pkg::timer_sel_t tmr_sel,
  input  logic                   tmr_done
);

  adc_if_pkg::align_state_t state;
  // previous request level for edge detect
  logic                     req_d;
  logic                     edgesel;
  logic                     chk_clear;
  logic                     chk_enable;

  // **************************************************
  // state machine
  // **************************************************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= adc_if_pkg::ST_IDLE;
      req_d      <= 1'b0;
      edgesel    <= 1'b0;
      chk_clear  <= 1'b0;
      chk_enable <= 1'b0;
      tmr_start  <= 1'b0;
      tmr_sel    <= adc_if_pkg::TMR_SETTLE;
      cal_ack    <= 1'b0;
      cal_ok     <= 1'b0;
    end else begin
      req_d <= cal_req;
      // one-cycle pulses
      tmr_start <= 1'b0;
      chk_clear <= 1'b0;
      unique case (state)
        adc_if_pkg::ST_IDLE: begin
          // new request, first trial with edgesel 0
          if (cal_req && !req_d) begin
            edgesel   <= 1'b0;
            tmr_start <= 1'b1;
            tmr_sel   <= adc_if_pkg::TMR_SETTLE;
            state     <= adc_if_pkg::ST_SETTLE;
          end
        end
        adc_if_pkg::ST_SETTLE: begin
          // capture pipeline refilled, open the compare window
          if (tmr_done) begin
            chk_clear  <= 1'b1;
            chk_enable <= 1'b1;
            tmr_start  <= 1'b1;
            tmr_sel    <= adc_if_pkg::TMR_WINDOW;
            state      <= adc_if_pkg::ST_CHECK;
          end
        end
        adc_if_pkg::ST_CHECK: begin
          if (tmr_done) begin
            chk_enable <= 1'b0;
            state      <= adc_if_pkg::ST_RESULT;
          end
        end
        adc_if_pkg::ST_RESULT: begin
          if (!align.chk_fail) begin
            cal_ok  <= 1'b1;
            cal_ack <= 1'b1;
            state   <= adc_if_pkg::ST_ACK;
          end else if (!edgesel) begin
            // retry with the other half-cycle pairing
            edgesel   <= 1'b1;
            tmr_start <= 1'b1;
            tmr_sel   <= adc_if_pkg::TMR_SETTLE;
            state     <= adc_if_pkg::ST_SETTLE;
          end else begin
            // both pairings failed, fall back to 0
            cal_ok  <= 1'b0;
            edgesel <= 1'b0;
            cal_ack <= 1'b1;
            state   <= adc_if_pkg::ST_ACK;
          end
        end
        adc_if_pkg::ST_ACK: begin
          // ack drops the cycle after the request falls
          if (!cal_req) begin
            cal_ack <= 1'b0;
            state   <= adc_if_pkg::ST_IDLE;
          end
        end
        default: begin
          state <= adc_if_pkg::ST_IDLE;
        end
      endcase
    end
  end

  assign align.edgesel    = edgesel;
  assign align.chk_clear  = chk_clear;
  assign align.chk_enable = chk_enable;

endmodule

//--- rtl/adc_align_if.sv
/* alignment control bundle
   edge select and pattern checker control between the calibration fsm,
   the ddr capture block and the pattern checker */

interface adc_align_if;

  // half-cycle pairing, 0 = rise/fall of the same cycle
  logic edgesel;

  // checker control, clear wipes the fail flag and history
  logic chk_clear;
  logic chk_enable;

  // sticky mismatch flag back to the fsm
  logic chk_fail;

  // calibration fsm owns the select and the checker control
  modport fsm_mp (
    output edgesel,
    output chk_clear,
    output chk_enable,
    input  chk_fail
  );

  // capture block only follows the select
  modport capture_mp (
    input edgesel
  );

  modport checker_mp (
    input  chk_clear,
    input  chk_enable,
    output chk_fail
  );

endinterface

//--- rtl/adc_ddr_capture.sv
/* ddr capture
   dual-edge capture of the adc lanes and over-range pin, edge select demux,
   bit interleave into one sample and over-range merge */

module adc_ddr_capture (
  input  logic                             adc_clk,
  input  logic                             arst_n,
  input  logic [adc_if_pkg::LANES-1:0]     data_in,
  input  logic                             or_in,
  adc_align_if.capture_mp                  align,
  output logic [adc_if_pkg::SAMPLE_W-1:0]  adc_data,
  output logic                             adc_or
);

  // over-range pin rides along as the top bit of each rail
  localparam int RAIL_W = adc_if_pkg::LANES + 1;

  logic [RAIL_W-1:0] pin_bus;
  // rising half, launched at the rising edge, caught at the falling edge
  logic [RAIL_W-1:0] neg_cap;
  // rising half moved into the rising edge domain
  logic [RAIL_W-1:0] rise_r;
  // falling half, caught at the next rising edge
  logic [RAIL_W-1:0] fall_q;
  // falling half one cycle older, pairs with the following rising half
  logic [RAIL_W-1:0] fall_d;
  // demux rails, even and odd bit positions of the sample
  logic [RAIL_W-1:0] dmux_even;
  logic [RAIL_W-1:0] dmux_odd;

  assign pin_bus = {or_in, data_in};

  // **************************************************
  // pin capture
  // **************************************************

  always_ff @(negedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      neg_cap <= '0;
    end else begin
      neg_cap <= pin_bus;
    end
  end

  // edgesel 0: rise(k) + fall(k), sample out 3 edges after edge k
  // edgesel 1: fall(k) + rise(k+1), sample out 3 edges after edge k+1
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      rise_r    <= '0;
      fall_q    <= '0;
      fall_d    <= '0;
      dmux_even <= '0;
      dmux_odd  <= '0;
    end else begin
      rise_r    <= neg_cap;
      fall_q    <= pin_bus;
      fall_d    <= fall_q;
      dmux_even <= align.edgesel ? fall_d : rise_r;
      dmux_odd  <= align.edgesel ? rise_r : fall_q;
    end
  end

  // **************************************************
  // interleave and over-range merge
  // **************************************************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      adc_data <= '0;
      adc_or   <= 1'b0;
    end else begin
      for (int i = 0; i < adc_if_pkg::LANES; i++) begin
        adc_data[2*i]   <= dmux_even[i];
        adc_data[2*i+1] <= dmux_odd[i];
      end
      // either half flags over-range for the whole sample
      adc_or <= dmux_even[RAIL_W-1] | dmux_odd[RAIL_W-1];
    end
  end

endmodule

//--- rtl/adc_if_pkg.sv
/* adc interface package
   sample geometry, adc test pattern words and the enums shared by
   the calibration fsm and the window timer */

package adc_if_pkg;

  // **************************************************
  // sample geometry
  // **************************************************

  // number of ddr data lanes on the adc port
  localparam int LANES = 8;

  // one sample is carried as two half-words, one per clock edge
  localparam int SAMPLE_W = 2 * LANES;

  // **************************************************
  // adc test mode
  // **************************************************

  // alternating test words sent by the adc during calibration
  // a sample built from the wrong half-cycle pair matches neither word
  localparam logic [SAMPLE_W-1:0] PATTERN_A = 16'hA53C;
  localparam logic [SAMPLE_W-1:0] PATTERN_B = 16'h5AC3;

  // **************************************************
  // control types
  // **************************************************

  // which length the window timer loads on start
  typedef enum logic {
    TMR_SETTLE,
    TMR_WINDOW
  } timer_sel_t;

  // calibration fsm states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETTLE,
    ST_CHECK,
    ST_RESULT,
    ST_ACK
  } align_state_t;

endpackage

//--- rtl/adc_if_top.sv
/* adc ddr interface top
   capture, pattern checker, window timer and calibration fsm */

module adc_if_top #(
  parameter int SETTLE_CYCLES = 8,
  parameter int WINDOW_CYCLES = 32
) (
  input  logic                             adc_clk,
  input  logic                             arst_n,
  input  logic [adc_if_pkg::LANES-1:0]     adc_data_in,
  input  logic                             adc_or_in,
  input  logic                             cal_req,
  output logic                             cal_ack,
  output logic                             cal_ok,
  output logic                             adc_edgesel,
  output logic [adc_if_pkg::SAMPLE_W-1:0]  adc_data,
  output logic                             adc_or
);

  // fsm to timer
  logic                   tmr_start;
  adc_if_pkg::timer_sel_t tmr_sel;
  logic                   tmr_done;

  adc_align_if align_if ();

  assign adc_edgesel = align_if.edgesel;

  adc_ddr_capture i_capture (
    .adc_clk  (adc_clk),
    .arst_n   (arst_n),
    .data_in  (adc_data_in),
    .or_in    (adc_or_in),
    .align    (align_if.capture_mp),
    .adc_data (adc_data),
    .adc_or   (adc_or)
  );

  // checker watches the same samples that leave the top
  adc_pattern_check i_check (
    .adc_clk  (adc_clk),
    .arst_n   (arst_n),
    .adc_data (adc_data),
    .chk      (align_if.checker_mp)
  );

  adc_window_timer #(
    .SETTLE_CYCLES (SETTLE_CYCLES),
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) i_timer (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .tmr_start (tmr_start),
    .tmr_sel   (tmr_sel),
    .tmr_done  (tmr_done)
  );

  adc_align_fsm i_fsm (
    .adc_clk   (adc_clk),
    .arst_n    (arst_n),
    .cal_req   (cal_req),
    .cal_ack   (cal_ack),
    .cal_ok    (cal_ok),
    .align     (align_if.fsm_mp),
    .tmr_start (tmr_start),
    .tmr_sel   (tmr_sel),
    .tmr_done  (tmr_done)
  );

endmodule

//--- rtl/adc_pattern_check.sv
/* test pattern checker
   compares captured samples against the alternating adc test pattern
   and keeps a sticky fail flag until cleared */

module adc_pattern_check (
  input  logic                             adc_clk,
  input  logic                             arst_n,
  input  logic [adc_if_pkg::SAMPLE_W-1:0]  adc_data,
  adc_align_if.checker_mp                  chk
);

  logic [adc_if_pkg::SAMPLE_W-1:0] prev_data;
  // set once a sample has been seen since the last clear
  logic                            have_prev;
  logic                            fail;
  logic                            is_pattern;
  logic                            repeated;

  // sample must be one of the two test words
  assign is_pattern = (adc_data == adc_if_pkg::PATTERN_A) ||
                      (adc_data == adc_if_pkg::PATTERN_B);

  // and must toggle against the previous one, first sample is free
  assign repeated = have_prev && (adc_data == prev_data);

  // **************************************************
  // history and sticky flag
  // **************************************************

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      have_prev <= 1'b0;
      fail      <= 1'b0;
    end else if (chk.chk_clear) begin
      // clear wins over enable
      have_prev <= 1'b0;
      fail      <= 1'b0;
    end else if (chk.chk_enable) begin
      have_prev <= 1'b1;
      if (!is_pattern || repeated) begin
        fail <= 1'b1;
      end
    end
  end

  // previous sample, only meaningful while have_prev is set
  always_ff @(posedge adc_clk) begin
    if (chk.chk_enable) begin
      prev_data <= adc_data;
    end
  end

  assign chk.chk_fail = fail;

endmodule

//--- rtl/adc_window_timer.sv
/* window timer
   down-counter for the pipeline settle time and the compare window */

module adc_window_timer #(
  parameter int SETTLE_CYCLES = 8,
  parameter int WINDOW_CYCLES = 32
) (
  input  logic                   adc_clk,
  input  logic                   arst_n,
  input  logic                   tmr_start,
  input  adc_if_pkg::timer_sel_t tmr_sel,
  output logic                   tmr_done
);

  localparam int MAX_LEN = (SETTLE_CYCLES > WINDOW_CYCLES) ? SETTLE_CYCLES : WINDOW_CYCLES;
  localparam int CNT_W   = $clog2(MAX_LEN + 1);

  // zero means idle
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] load_len;

  assign load_len = (tmr_sel == adc_if_pkg::TMR_WINDOW) ? CNT_W'(WINDOW_CYCLES)
                                                        : CNT_W'(SETTLE_CYCLES);

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (tmr_start) begin
      // restart reloads even when still running
      count <= load_len;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // last count, N cycles after the start pulse
  assign tmr_done = (count == CNT_W'(1));

endmodule

//--- run.sh
#!/usr/bin/env bash
# compile and run the adc interface testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_adc_if -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/Vtb_adc_if)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# pass only when the testbench printed its pass line
if echo "$sim_out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

//--- sim/adc_if_assertions.sv
/* calibration handshake checks
   bound into the calibration fsm to watch the four-phase handshake
   and the result select */

module tb_adc_if_assertions (
  input logic adc_clk,
  input logic arst_n,
  input logic cal_req,
  input logic cal_ack,
  input logic edgesel
);
  timeunit 1ns;
  timeprecision 100ps;

  // ack only answers a live request
  ack_needs_req: assert property (@(posedge adc_clk) disable iff (!arst_n)
    $rose(cal_ack) |-> cal_req)
    else $error("cal_ack rose while cal_req was low");

  // ack drops the cycle after the request falls (phase 4)
  ack_follows_req: assert property (@(posedge adc_clk) disable iff (!arst_n)
    $fell(cal_req) && cal_ack |=> !cal_ack)
    else $error("cal_ack stayed high after cal_req fell");

  // result select is frozen while acknowledged
  sel_stable: assert property (@(posedge adc_clk) disable iff (!arst_n)
    cal_ack && $past(cal_ack) |-> $stable(edgesel))
    else $error("edgesel changed while cal_ack was high");

endmodule

bind adc_align_fsm tb_adc_if_assertions i_assertions (
  .adc_clk (adc_clk),
  .arst_n  (arst_n),
  .cal_req (cal_req),
  .cal_ack (cal_ack),
  .edgesel (edgesel)
);

//--- sim/tb_adc_if.sv
/* adc ddr interface testbench
   directed tests for the capture path, over-range merge and calibration */

module tb_adc_if;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LANES   = adc_if_pkg::LANES;
  localparam int SETTLE  = 8;
  localparam int WINDOW  = 32;
  localparam int N_RAND  = 64;
  // two calibration trials plus handshake slack
  localparam int CAL_LEN = 2 * (SETTLE + WINDOW + 4) + 24;
  // reset, two data streams, over-range stream, four calibration drives, margin
  localparam int WDOG_CYCLES = 10 + 2 * (N_RAND + 5) + 13 + 4 * (CAL_LEN + 5) + 200;

  logic                            adc_clk;
  logic                            arst_n;
  logic [LANES-1:0]                adc_data_in;
  logic                            adc_or_in;
  logic                            cal_req;
  logic                            cal_ack;
  logic                            cal_ok;
  logic                            adc_edgesel;
  logic [adc_if_pkg::SAMPLE_W-1:0] adc_data;
  logic                            adc_or;

  int errors;
  int checks;
  int seed;
  // stimulus words {or second half, or first half, sample}
  logic [17:0]    words_q[$];
  // half-words in pin order, over-range on top
  logic [LANES:0] half_log[$];
  // {adc_or, adc_data} after each rising edge
  logic [16:0]    got_q[$];

  adc_if_top #(
    .SETTLE_CYCLES (SETTLE),
    .WINDOW_CYCLES (WINDOW)
  ) i_dut (
    .adc_clk     (adc_clk),
    .arst_n      (arst_n),
    .adc_data_in (adc_data_in),
    .adc_or_in   (adc_or_in),
    .cal_req     (cal_req),
    .cal_ack     (cal_ack),
    .cal_ok      (cal_ok),
    .adc_edgesel (adc_edgesel),
    .adc_data    (adc_data),
    .adc_or      (adc_or)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  // **************************************************
  // helpers
  // **************************************************

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  // first half goes on the even bits, second half on the odd bits
  function automatic logic [LANES:0] half_of(input logic [17:0] w, input int odd);
    logic [LANES:0] h;
    h[LANES] = w[16 + odd];
    for (int i = 0; i < LANES; i++) begin
      h[i] = w[2*i + odd];
    end
    return h;
  endfunction

  // reference pairing, over-range is the OR of both halves
  function automatic logic [16:0] pair_sample(input logic [LANES:0] first,
                                              input logic [LANES:0] second);
    logic [16:0] s;
    s[16] = first[LANES] | second[LANES];
    for (int i = 0; i < LANES; i++) begin
      s[2*i]     = first[i];
      s[2*i + 1] = second[i];
    end
    return s;
  endfunction

  function automatic void fill_pattern(input int n);
    words_q.delete();
    for (int j = 0; j < n; j++) begin
      words_q.push_back({2'b00, (j % 2 == 0) ? adc_if_pkg::PATTERN_A : adc_if_pkg::PATTERN_B});
    end
  endfunction

  function automatic void fill_random(input int n);
    words_q.delete();
    for (int j = 0; j < n; j++) begin
      words_q.push_back({2'b00, 16'($random(seed))});
    end
  endfunction

  task automatic put_half(input logic [LANES:0] h);
    {adc_or_in, adc_data_in} <= h;
    half_log.push_back(h);
  endtask

  // aligned words start on a rising edge, offset words on a falling edge
  task automatic drive_pins(input logic [17:0] words[$], input bit offset);
    @(posedge adc_clk);
    if (offset) begin
      // rising half of the first cycle still carries the old pins
      half_log.push_back({adc_or_in, adc_data_in});
    end
    foreach (words[j]) begin
      if (offset) begin
        @(negedge adc_clk);
      end else if (j > 0) begin
        @(posedge adc_clk);
      end
      put_half(half_of(words[j], 0));
      if (offset) begin
        @(posedge adc_clk);
      end else begin
        @(negedge adc_clk);
      end
      put_half(half_of(words[j], 1));
    end
  endtask

  task automatic collect_samples(input int n_edges);
    repeat (n_edges) begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      got_q.push_back({adc_or, adc_data});
    end
  endtask

  // pair p is seen 3 edges after the cycle of its first half, 4 with offset
  task automatic stream_and_compare(input bit offset, input string name);
    int off;
    int lag;
    logic [16:0] exp_s;
    off = offset ? 1 : 0;
    lag = 3 + off;
    half_log.delete();
    got_q.delete();
    fork
      drive_pins(words_q, offset);
      collect_samples(words_q.size() + 5);
    join
    for (int p = 0; p < words_q.size(); p++) begin
      exp_s = pair_sample(half_log[2*p + off], half_log[2*p + off + 1]);
      check_value({name, " adc_data"}, 32'(got_q[p + lag][15:0]), 32'(exp_s[15:0]));
      check_value({name, " adc_or"}, 32'(got_q[p + lag][16]), 32'(exp_s[16]));
    end
  endtask

  task automatic calibrate(input logic exp_ok, input logic exp_sel, input string name);
    int wait_n;
    wait_n = 0;
    @(posedge adc_clk);
    cal_req <= 1'b1;
    @(negedge adc_clk);
    while (!cal_ack && wait_n < CAL_LEN) begin
      @(negedge adc_clk);
      wait_n++;
    end
    if (!cal_ack) begin
      $display("%s: cal_ack did not rise within %0d cycles of the request", name, CAL_LEN);
      errors++;
    end
    check_value({name, " cal_ok"}, 32'(cal_ok), 32'(exp_ok));
    check_value({name, " adc_edgesel"}, 32'(adc_edgesel), 32'(exp_sel));
    // drop the request, ack follows one cycle later
    @(posedge adc_clk);
    cal_req <= 1'b0;
    repeat (2) @(negedge adc_clk);
    check_value({name, " cal_ack"}, 32'(cal_ack), 32'h0);
    check_value({name, " cal_ok held"}, 32'(cal_ok), 32'(exp_ok));
  endtask

  // **************************************************
  // directed tests
  // **************************************************

  task automatic reset_values();
    @(negedge adc_clk);
    check_value("cal_ack", 32'(cal_ack), 32'h0);
    check_value("cal_ok", 32'(cal_ok), 32'h0);
    check_value("adc_edgesel", 32'(adc_edgesel), 32'h0);
    check_value("adc_or", 32'(adc_or), 32'h0);
    check_value("adc_data", 32'(adc_data), 32'h0);
  endtask

  task automatic edgesel0_path();
    fill_random(N_RAND);
    stream_and_compare(1'b0, "edgesel 0");
  endtask

  // flags in the rising half, falling half, both or neither
  task automatic overrange_merge();
    words_q.delete();
    for (int j = 0; j < 8; j++) begin
      words_q.push_back({2'(j % 4), 16'($random(seed))});
    end
    stream_and_compare(1'b0, "over-range");
  endtask

  task automatic aligned_calibration();
    fill_pattern(CAL_LEN);
    fork
      drive_pins(words_q, 1'b0);
      calibrate(1'b1, 1'b0, "aligned cal");
    join
  endtask

  task automatic offset_calibration();
    fill_pattern(CAL_LEN);
    fork
      drive_pins(words_q, 1'b1);
      calibrate(1'b1, 1'b1, "offset cal");
    join
    fill_random(N_RAND);
    stream_and_compare(1'b1, "edgesel 1");
  endtask

  task automatic failed_calibration();
    fill_random(CAL_LEN);
    fork
      drive_pins(words_q, 1'b0);
      calibrate(1'b0, 1'b0, "failed cal");
    join
    // new request only once ack is back low
    check_value("cal_ack before second request", 32'(cal_ack), 32'h0);
    fill_pattern(CAL_LEN);
    fork
      drive_pins(words_q, 1'b0);
      calibrate(1'b1, 1'b0, "second cal");
    join
  endtask

  initial begin
    seed        = 32'h74a;
    errors      = 0;
    checks      = 0;
    arst_n      = 1'b0;
    cal_req     = 1'b0;
    adc_data_in = '0;
    adc_or_in   = 1'b0;
    repeat (5) @(posedge adc_clk);
    arst_n <= 1'b1;
    reset_values();
    edgesel0_path();
    overrange_merge();
    aligned_calibration();
    offset_calibration();
    failed_calibration();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WDOG_CYCLES * 8);
    $display("watchdog expired before the directed tests completed");
    $display("tests failed");
    $finish;
  end

endmodule
